// ==== verilog.f ====
rtl/vga_pkg.sv
rtl/vga_config_regs.sv
rtl/vga_cpu_mem.sv
rtl/vga_scan_fetch.sv
rtl/vga_mem_arbiter.sv
rtl/vga.sv
verification/vga_checker.sv
verification/vga_monitor.sv
verification/vga_tb.sv

// ==== verification/vga_tb.sv ====
// VGA testbench: clock, reset, SRAM model, Wishbone accesses and the test sequence
module vga_tb;

  localparam int H_TOT = 26;
  localparam int H_DISP = 16;
  localparam int H_SS = 18;
  localparam int H_SE = 22;
  localparam int V_TOT = 10;
  localparam int V_DISP = 6;
  localparam int V_SS = 7;
  localparam int V_SE = 8;
  localparam int SEED = 32'h9eb3;
  localparam int ACK_MAX = 200;

  logic        wb_clk_i = 1'b0;
  logic        rst_n_i = 1'b0;
  logic [15:0] wb_dat_i = '0;
  logic [15:0] wb_dat_o;
  logic [15:0] wb_adr_i = '0;
  logic        wb_we_i = 1'b0;
  logic        wb_tga_i = 1'b0;
  logic [1:0]  wb_sel_i = '0;
  logic        wb_stb_i = 1'b0;
  logic        wb_cyc_i = 1'b0;
  logic        wb_ack_o;
  logic [15:0] sram_adr_o;
  logic        sram_we_o;
  logic [1:0]  sram_sel_o;
  logic [15:0] sram_dat_o;
  logic [15:0] sram_rd_q = '0;
  logic        vga_hsync_o;
  logic        vga_vsync_o;
  logic        vga_de_o;
  logic [3:0]  vga_pix_o;
  logic [15:0] sram [65536];
  logic [15:0] cur_start = '0;

  always #4 wb_clk_i = ~wb_clk_i;

  vga #(.ADDR_W(16), .FIFO_DEPTH(4)) i_vga (
    .wb_clk_i, .rst_n_i, .wb_dat_i, .wb_dat_o, .wb_adr_i, .wb_we_i, .wb_tga_i,
    .wb_sel_i, .wb_stb_i, .wb_cyc_i, .wb_ack_o, .sram_adr_o, .sram_we_o,
    .sram_sel_o, .sram_dat_o, .sram_dat_i(sram_rd_q), .vga_hsync_o, .vga_vsync_o,
    .vga_de_o, .vga_pix_o
  );

  vga_monitor #(.H_TOT(H_TOT), .H_DISP(H_DISP), .H_SS(H_SS), .H_SE(H_SE), .V_TOT(V_TOT),
                .V_DISP(V_DISP), .V_SS(V_SS), .V_SE(V_SE)) i_monitor (
    .wb_clk_i, .frame_addr_i(cur_start), .vga_hsync_i(vga_hsync_o),
    .vga_vsync_i(vga_vsync_o), .vga_de_i(vga_de_o), .vga_pix_i(vga_pix_o)
  );

  // Synchronous SRAM with byte lanes and one cycle read latency
  always @(posedge wb_clk_i) begin
    if (sram_we_o && sram_sel_o[0]) sram[sram_adr_o][7:0] <= sram_dat_o[7:0];
    if (sram_we_o && sram_sel_o[1]) sram[sram_adr_o][15:8] <= sram_dat_o[15:8];
    sram_rd_q <= sram[sram_adr_o];
  end

  task automatic abort_run(string what);
    $display("%s", what);
    $display("test failed");
    $finish;
  endtask

  task automatic bus_access(input logic tag, input logic we, input logic [15:0] adr,
                            input logic [1:0] sel, input logic [15:0] dat,
                            output logic [15:0] rdat);
    int n;
    @(posedge wb_clk_i);
    #1;
    {wb_tga_i, wb_we_i, wb_adr_i, wb_sel_i, wb_dat_i} = {tag, we, adr, sel, dat};
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    n = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      n++;
      if (n > ACK_MAX) abort_run("Wishbone access got no ack before the timeout");
    end while (!wb_ack_o);
    rdat = wb_dat_o;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i = 1'b0;
  endtask

  task automatic wait_frames(int n);
    int target;
    int cnt;
    target = i_monitor.frames + n;
    cnt = 0;
    while (i_monitor.frames < target) begin
      @(posedge wb_clk_i);
      #1;
      cnt++;
      if (cnt > (n + 3) * H_TOT * V_TOT * 2) abort_run("video frames stopped advancing");
    end
  endtask

  // Masked lanes keep the old byte, the mask is the one last programmed
  task automatic cpu_write_read(logic [15:0] adr, logic [15:0] dat, logic [1:0] mask);
    logic [15:0] rd;
    logic [15:0] exp;
    exp = i_monitor.merge_word(i_monitor.shadow[adr], dat, mask);
    bus_access(1'b0, 1'b1, adr, 2'b11, dat, rd);
    i_monitor.shadow[adr] = exp;
    i_monitor.check_value("sram word", exp, sram[adr]);
    bus_access(1'b0, 1'b0, adr, 2'b11, 16'h0, rd);
    i_monitor.check_value("wb_dat_o", exp, rd);
  endtask

  initial begin
    logic [15:0] rd;
    logic [15:0] v;
    logic [1:0]  sel;
    int timing [8];
    void'($urandom(SEED));
    for (int a = 0; a < 65536; a++) begin
      v = 16'(a * 40503) ^ 16'(a >> 7);
      sram[a] = v;
      i_monitor.shadow[a] = v;
    end
    repeat (3) @(posedge wb_clk_i);
    #1 rst_n_i = 1'b1;

    // Each register goes back to zero so no partial timing starts a scan
    for (int a = 0; a < 16; a++) begin
      v = 16'($urandom);
      sel = 2'($urandom_range(1, 3));
      bus_access(1'b1, 1'b1, 16'(a), sel, v, rd);
      bus_access(1'b1, 1'b0, 16'(a), 2'b11, 16'h0, rd);
      i_monitor.check_value("cfg register", i_monitor.ref_reg(a, 16'h0, v, sel), rd);
      bus_access(1'b1, 1'b1, 16'(a), 2'b11, 16'h0, rd);
    end
    i_monitor.report_test("config registers");

    timing = '{H_TOT, H_DISP, H_SS, H_SE, V_TOT, V_DISP, V_SS, V_SE};
    for (int a = 0; a < 8; a++) bus_access(1'b1, 1'b1, 16'(a), 2'b11, 16'(timing[a]), rd);
    bus_access(1'b1, 1'b1, 16'd8, 2'b11, 16'h0100, rd);
    cur_start = 16'h0100;
    bus_access(1'b1, 1'b1, 16'd9, 2'b11, 16'h0003, rd);

    for (int i = 0; i < 16; i++) begin
      cpu_write_read(16'h8000 | 16'($urandom), 16'($urandom), 2'b11);
    end
    i_monitor.report_test("cpu memory");

    for (int m = 1; m < 3; m++) begin
      bus_access(1'b1, 1'b1, 16'd9, 2'b11, 16'(m), rd);
      for (int i = 0; i < 8; i++) begin
        cpu_write_read(16'h8000 | 16'($urandom), 16'($urandom), 2'(m));
      end
    end
    bus_access(1'b1, 1'b1, 16'd9, 2'b11, 16'h0003, rd);
    i_monitor.report_test("map mask");

    i_monitor.run = 1'b1;
    wait_frames(2);
    i_monitor.report_test("sync timing");

    bus_access(1'b1, 1'b1, 16'd8, 2'b11, 16'h0400, rd);
    cur_start = 16'h0400;
    wait_frames(3);
    i_monitor.report_test("pixel stream");

    for (int i = 0; i < 16; i++) begin
      cpu_write_read(16'h8000 | 16'($urandom), 16'($urandom), 2'b11);
    end
    wait_frames(1);
    i_monitor.report_test("cpu during display");

    $display("checks=%0d errors=%0d assertion_fails=%0d", i_monitor.checks,
             i_monitor.errors, i_vga.i_checker.fails);
    if (i_monitor.errors == 0 && i_vga.i_checker.fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== verification/vga_monitor.sv ====
// VGA monitor: reference model of timing, pixels and masked writes, compares DUT outputs
module vga_monitor #(
  parameter int H_TOT = 26,
  parameter int H_DISP = 16,
  parameter int H_SS = 18,
  parameter int H_SE = 22,
  parameter int V_TOT = 10,
  parameter int V_DISP = 6,
  parameter int V_SS = 7,
  parameter int V_SE = 8
) (
  input logic        wb_clk_i,
  input logic [15:0] frame_addr_i,
  input logic        vga_hsync_i,
  input logic        vga_vsync_i,
  input logic        vga_de_i,
  input logic [3:0]  vga_pix_i
);

  logic [15:0] shadow [65536];
  logic [15:0] frame_start;
  logic        run = 1'b0;
  logic        lock = 1'b0;
  logic        vsync_q = 1'b0;
  int          falls = 0;
  int          mh;
  int          mv;
  int          frames = 0;
  int          errors = 0;
  int          checks = 0;
  int          last_errors = 0;

  function automatic logic [15:0] merge_word(logic [15:0] old, logic [15:0] nw, logic [1:0] sel);
    return {sel[1] ? nw[15:8] : old[15:8], sel[0] ? nw[7:0] : old[7:0]};
  endfunction

  // Timing registers are 10 bits, map mask 2 bits, unused addresses read zero
  function automatic logic [15:0] ref_reg(int adr, logic [15:0] old, logic [15:0] nw,
                                          logic [1:0] sel);
    logic [15:0] m;
    m = merge_word(old, nw, sel);
    if (adr < 8) return m & 16'h03ff;
    if (adr == 8) return m;
    if (adr == 9) return m & 16'h0003;
    return 16'h0000;
  endfunction

  function automatic logic [3:0] ref_pixel(logic [15:0] start, int h, int v);
    logic [15:0] word;
    word = shadow[16'(start + v * (H_DISP / 4) + h / 4)];
    return word[(3 - h % 4) * 4 +: 4];
  endfunction

  task automatic check_value(string name, logic [15:0] exp, logic [15:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("MISMATCH time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic report_test(string name);
    $display("%s: %0d errors", name, errors - last_errors);
    last_errors = errors;
  endtask

  // Lock onto line 0 after two complete vertical syncs
  always @(posedge wb_clk_i) begin
    if (run && !lock) begin
      if (vsync_q && !vga_vsync_i) falls++;
      if (falls >= 2 && vga_de_i) begin
        lock = 1'b1;
        mh = 0;
        mv = 0;
        frame_start = frame_addr_i;
      end
    end
    vsync_q <= vga_vsync_i;
    if (lock) begin
      check_value("vga_hsync_o", 16'(mh >= H_SS && mh < H_SE), 16'(vga_hsync_i));
      check_value("vga_vsync_o", 16'(mv >= V_SS && mv < V_SE), 16'(vga_vsync_i));
      check_value("vga_de_o", 16'(mh < H_DISP && mv < V_DISP), 16'(vga_de_i));
      if (mh < H_DISP && mv < V_DISP) begin
        check_value("vga_pix_o", 16'(ref_pixel(frame_start, mh, mv)), 16'(vga_pix_i));
      end
      if (mh == H_TOT - 1) begin
        mh = 0;
        // Address reload at the end of the last visible line
        if (mv == V_DISP - 1) frame_start = frame_addr_i;
        if (mv == V_TOT - 1) begin
          mv = 0;
          frames++;
        end else begin
          mv++;
        end
      end else begin
        mh++;
      end
    end
  end

endmodule

// ==== verification/vga_checker.sv ====
// VGA checker: assertions on FIFO underrun, CPU request stability and the Wishbone ack pulse
module vga_checker (
  input logic              wb_clk_i,
  input logic              rst_n_i,
  input logic              wb_ack_i,
  input logic              vga_de_i,
  input logic              fifo_empty_i,
  input logic              fetch_run_i,
  input logic              cpu_valid_i,
  input logic              cpu_ready_i,
  input vga_pkg::mem_req_t cpu_req_i
);

  int fails = 0;

  // Once fetching runs the FIFO must never starve the active region
  underrun_a: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (vga_de_i && fetch_run_i) |-> !fifo_empty_i)
    else begin
      $error("pixel FIFO ran empty during display-enable");
      fails++;
    end

  // Scan side never stalls so back-pressure only reaches the CPU channel
  req_stable_a: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    (cpu_valid_i && !cpu_ready_i) |=> (cpu_valid_i && $stable(cpu_req_i)))
    else begin
      $error("CPU request changed while waiting for ready");
      fails++;
    end

  ack_pulse_a: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("Wishbone ack held high for more than one cycle");
      fails++;
    end

endmodule

bind vga vga_checker i_checker (
  .wb_clk_i     (wb_clk_i),
  .rst_n_i      (rst_n_i),
  .wb_ack_i     (wb_ack_o),
  .vga_de_i     (vga_de_o),
  .fifo_empty_i (i_scan_fetch.fifo_empty),
  .fetch_run_i  (i_scan_fetch.fetch_run_q),
  .cpu_valid_i  (cpu_valid),
  .cpu_ready_i  (cpu_ready),
  .cpu_req_i    (cpu_req)
);

// ==== rtl/vga.sv ====
// VGA adapter top level: Wishbone tag decode, config registers, CPU port, scan engine, arbiter
module vga #(
  parameter int ADDR_W     = vga_pkg::ADDR_W_DEF,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              wb_clk_i,
  input  logic              rst_n_i,
  input  logic [15:0]       wb_dat_i,
  output logic [15:0]       wb_dat_o,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic              wb_we_i,
  input  logic              wb_tga_i,
  input  logic [1:0]        wb_sel_i,
  input  logic              wb_stb_i,
  input  logic              wb_cyc_i,
  output logic              wb_ack_o,
  output logic [ADDR_W-1:0] sram_adr_o,
  output logic              sram_we_o,
  output logic [1:0]        sram_sel_o,
  output logic [15:0]       sram_dat_o,
  input  logic [15:0]       sram_dat_i,
  output logic              vga_hsync_o,
  output logic              vga_vsync_o,
  output logic              vga_de_o,
  output logic [3:0]        vga_pix_o
);

  import vga_pkg::*;

  logic        stb;
  logic [15:0] conf_dat;
  logic        conf_ack;
  logic [15:0] mem_dat;
  logic        mem_ack;
  vga_cfg_t    cfg;
  mem_req_t    cpu_req;
  logic        cpu_valid;
  logic        cpu_ready;
  logic        cpu_rd_valid;
  mem_req_t    scan_req;
  logic        scan_valid;
  logic        scan_ready;
  logic        scan_rd_valid;
  logic [15:0] rd_data;

  // Tag high selects the registers, tag low the frame memory
  assign stb      = wb_stb_i & wb_cyc_i;
  assign wb_dat_o = wb_tga_i ? conf_dat : mem_dat;
  assign wb_ack_o = wb_tga_i ? conf_ack : mem_ack;

  vga_config_regs i_config_regs (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .wb_stb_i (stb & wb_tga_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i[3:0]),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (conf_dat),
    .wb_ack_o (conf_ack),
    .cfg_o    (cfg)
  );

  vga_cpu_mem #(.ADDR_W(ADDR_W)) i_cpu_mem (
    .wb_clk_i    (wb_clk_i),
    .rst_n_i     (rst_n_i),
    .wb_stb_i    (stb & ~wb_tga_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .cfg_i       (cfg),
    .wb_dat_o    (mem_dat),
    .wb_ack_o    (mem_ack),
    .cpu_req_o   (cpu_req),
    .cpu_valid_o (cpu_valid),
    .cpu_ready_i (cpu_ready),
    .rd_valid_i  (cpu_rd_valid),
    .rd_data_i   (rd_data)
  );

  vga_scan_fetch #(.ADDR_W(ADDR_W), .FIFO_DEPTH(FIFO_DEPTH)) i_scan_fetch (
    .wb_clk_i     (wb_clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_i        (cfg),
    .scan_req_o   (scan_req),
    .scan_valid_o (scan_valid),
    .scan_ready_i (scan_ready),
    .rd_valid_i   (scan_rd_valid),
    .rd_data_i    (rd_data),
    .vga_hsync_o  (vga_hsync_o),
    .vga_vsync_o  (vga_vsync_o),
    .vga_de_o     (vga_de_o),
    .vga_pix_o    (vga_pix_o)
  );

  vga_mem_arbiter #(.ADDR_W(ADDR_W)) i_mem_arbiter (
    .wb_clk_i        (wb_clk_i),
    .rst_n_i         (rst_n_i),
    .scan_req_i      (scan_req),
    .scan_valid_i    (scan_valid),
    .scan_ready_o    (scan_ready),
    .cpu_req_i       (cpu_req),
    .cpu_valid_i     (cpu_valid),
    .cpu_ready_o     (cpu_ready),
    .scan_rd_valid_o (scan_rd_valid),
    .cpu_rd_valid_o  (cpu_rd_valid),
    .rd_data_o       (rd_data),
    .sram_adr_o      (sram_adr_o),
    .sram_we_o       (sram_we_o),
    .sram_sel_o      (sram_sel_o),
    .sram_dat_o      (sram_dat_o),
    .sram_dat_i      (sram_dat_i)
  );

endmodule

// ==== rtl/vga_mem_arbiter.sv ====
// VGA memory arbiter: fixed-priority merge of scan and CPU requests onto the SRAM port
module vga_mem_arbiter #(
  parameter int ADDR_W = vga_pkg::ADDR_W_DEF
) (
  input  logic              wb_clk_i,
  input  logic              rst_n_i,
  input  vga_pkg::mem_req_t scan_req_i,
  input  logic              scan_valid_i,
  output logic              scan_ready_o,
  input  vga_pkg::mem_req_t cpu_req_i,
  input  logic              cpu_valid_i,
  output logic              cpu_ready_o,
  output logic              scan_rd_valid_o,
  output logic              cpu_rd_valid_o,
  output logic [15:0]       rd_data_o,
  output logic [ADDR_W-1:0] sram_adr_o,
  output logic              sram_we_o,
  output logic [1:0]        sram_sel_o,
  output logic [15:0]       sram_dat_o,
  input  logic [15:0]       sram_dat_i
);

  import vga_pkg::*;

  mem_req_t win_req;
  logic     scan_xfer;
  logic     cpu_xfer;

  // SRAM takes a request every cycle, scan always wins
  assign scan_ready_o = 1'b1;
  assign cpu_ready_o  = ~scan_valid_i;

  assign scan_xfer = scan_valid_i & scan_ready_o;
  assign cpu_xfer  = cpu_valid_i & cpu_ready_o;
  assign win_req   = scan_valid_i ? scan_req_i : cpu_req_i;

  assign sram_adr_o = ADDR_W'(win_req.addr);
  assign sram_we_o  = win_req.we & (scan_xfer | cpu_xfer);
  assign sram_sel_o = win_req.sel;
  assign sram_dat_o = win_req.wdata;

  // Read data lands one cycle after its address, shared by both sides
  assign rd_data_o = sram_dat_i;

  // Owner of the read in flight
  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      scan_rd_valid_o <= 1'b0;
      cpu_rd_valid_o  <= 1'b0;
    end else begin
      scan_rd_valid_o <= scan_xfer & ~scan_req_i.we;
      cpu_rd_valid_o  <= cpu_xfer & ~cpu_req_i.we;
    end
  end

endmodule

// ==== rtl/vga_scan_fetch.sv ====
// VGA scan engine: sync timing, frame word prefetch into a FIFO and 4-bit pixel shifting
module vga_scan_fetch #(
  parameter int ADDR_W     = vga_pkg::ADDR_W_DEF,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              wb_clk_i,
  input  logic              rst_n_i,
  input  vga_pkg::vga_cfg_t cfg_i,
  output vga_pkg::mem_req_t scan_req_o,
  output logic              scan_valid_o,
  input  logic              scan_ready_i,
  input  logic              rd_valid_i,
  input  logic [15:0]       rd_data_i,
  output logic              vga_hsync_o,
  output logic              vga_vsync_o,
  output logic              vga_de_o,
  output logic [3:0]        vga_pix_o
);

  // Depth is a power of two, pointers wrap on their own
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [9:0]        h_cnt;
  logic [9:0]        v_cnt;
  logic              line_end;
  logic              frame_end;
  logic              flush;
  logic              fetch_run_q;
  logic [ADDR_W-1:0] fetch_addr;
  logic [15:0]       fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fifo_cnt;
  logic [CNT_W-1:0]  pend_cnt;
  logic              fifo_empty;
  logic              req_xfer;
  logic              push;
  logic              pop;
  logic [15:0]       head;

  assign line_end  = (h_cnt >= cfg_i.h_total - 10'd1);
  assign frame_end = line_end && (v_cnt >= cfg_i.v_total - 10'd1);
  // End of the last visible line, blanking follows for the refill
  assign flush     = line_end && (v_cnt == cfg_i.v_disp - 10'd1);

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      h_cnt <= 10'd0;
      v_cnt <= 10'd0;
    end else if (line_end) begin
      h_cnt <= 10'd0;
      v_cnt <= frame_end ? 10'd0 : v_cnt + 10'd1;
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  assign vga_hsync_o = (h_cnt >= cfg_i.h_sync_start) && (h_cnt < cfg_i.h_sync_end);
  assign vga_vsync_o = (v_cnt >= cfg_i.v_sync_start) && (v_cnt < cfg_i.v_sync_end);
  assign vga_de_o    = (h_cnt < cfg_i.h_disp) && (v_cnt < cfg_i.v_disp);

  // Outstanding fetches count against FIFO room
  assign scan_valid_o = fetch_run_q && !flush && ((fifo_cnt + pend_cnt) < FIFO_DEPTH);
  assign scan_req_o   = '{addr: 16'(fetch_addr), we: 1'b0, sel: 2'b11, wdata: 16'h0000};
  assign req_xfer     = scan_valid_o && scan_ready_i;

  assign fifo_empty = (fifo_cnt == '0);
  assign push       = rd_valid_i && !flush;
  // Word retires after its fourth pixel
  assign pop        = vga_de_o && (h_cnt[1:0] == 2'b11) && !fifo_empty;

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      fetch_run_q <= 1'b0;
      fetch_addr  <= '0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fifo_cnt    <= '0;
      pend_cnt    <= '0;
    end else if (flush) begin
      // Fetch starts at the first frame boundary
      fetch_run_q <= 1'b1;
      fetch_addr  <= ADDR_W'(cfg_i.start_addr);
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fifo_cnt    <= '0;
      pend_cnt    <= '0;
    end else begin
      if (req_xfer) begin
        fetch_addr <= fetch_addr + 1'b1;
      end
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
      pend_cnt <= pend_cnt + CNT_W'(req_xfer) - CNT_W'(rd_valid_i);
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr] <= rd_data_i;
    end
  end

  assign head = fifo_mem[rd_ptr];

  // Leftmost pixel in the top nibble, zero on underrun
  assign vga_pix_o = (vga_de_o && !fifo_empty) ? head[{~h_cnt[1:0], 2'b00} +: 4] : 4'h0;

endmodule

// ==== rtl/vga_cpu_mem.sv ====
// VGA CPU memory port: turns Wishbone frame-memory accesses into masked SRAM requests
module vga_cpu_mem #(
  parameter int ADDR_W = vga_pkg::ADDR_W_DEF
) (
  input  logic              wb_clk_i,
  input  logic              rst_n_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [1:0]        wb_sel_i,
  input  logic [15:0]       wb_dat_i,
  input  vga_pkg::vga_cfg_t cfg_i,
  output logic [15:0]       wb_dat_o,
  output logic              wb_ack_o,
  output vga_pkg::mem_req_t cpu_req_o,
  output logic              cpu_valid_o,
  input  logic              cpu_ready_i,
  input  logic              rd_valid_i,
  input  logic [15:0]       rd_data_i
);

  import vga_pkg::*;

  cpu_state_e state_q;
  cpu_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (wb_stb_i) begin
          state_d = REQ;
        end
      end
      REQ: begin
        if (cpu_ready_i) begin
          state_d = cpu_req_o.we ? ACK : WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (rd_valid_i) begin
          state_d = ACK;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request captured once per access; map mask only gates write lanes
  always_ff @(posedge wb_clk_i) begin
    if (state_q == IDLE && wb_stb_i) begin
      cpu_req_o.addr  <= 16'(wb_adr_i);
      cpu_req_o.we    <= wb_we_i;
      cpu_req_o.sel   <= wb_we_i ? (wb_sel_i & cfg_i.map_mask) : wb_sel_i;
      cpu_req_o.wdata <= wb_dat_i;
    end
    if (state_q == WAIT_DATA && rd_valid_i) begin
      wb_dat_o <= rd_data_i;
    end
  end

  assign cpu_valid_o = (state_q == REQ);
  assign wb_ack_o    = (state_q == ACK);

endmodule

// ==== rtl/vga_config_regs.sv ====
// VGA configuration block: Wishbone slave for timing, start address and map mask registers
module vga_config_regs (
  input  logic              wb_clk_i,
  input  logic              rst_n_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [3:0]        wb_adr_i,
  input  logic [1:0]        wb_sel_i,
  input  logic [15:0]       wb_dat_i,
  output logic [15:0]       wb_dat_o,
  output logic              wb_ack_o,
  output vga_pkg::vga_cfg_t cfg_o
);

  import vga_pkg::*;

  cfg_reg_e    reg_sel;
  logic        access;
  logic [15:0] rd_val;
  logic [15:0] wr_val;

  assign reg_sel = cfg_reg_e'(wb_adr_i);
  // A held strobe starts no second access while ack is out
  assign access  = wb_stb_i & ~wb_ack_o;

  always_comb begin
    case (reg_sel)
      H_TOTAL:      rd_val = {6'd0, cfg_o.h_total};
      H_DISP:       rd_val = {6'd0, cfg_o.h_disp};
      H_SYNC_START: rd_val = {6'd0, cfg_o.h_sync_start};
      H_SYNC_END:   rd_val = {6'd0, cfg_o.h_sync_end};
      V_TOTAL:      rd_val = {6'd0, cfg_o.v_total};
      V_DISP:       rd_val = {6'd0, cfg_o.v_disp};
      V_SYNC_START: rd_val = {6'd0, cfg_o.v_sync_start};
      V_SYNC_END:   rd_val = {6'd0, cfg_o.v_sync_end};
      START_ADDR:   rd_val = cfg_o.start_addr;
      MAP_MASK:     rd_val = {14'd0, cfg_o.map_mask};
      default:      rd_val = 16'h0000;
    endcase
  end

  // Unselected byte lanes keep the current contents
  assign wr_val = {wb_sel_i[1] ? wb_dat_i[15:8] : rd_val[15:8],
                   wb_sel_i[0] ? wb_dat_i[7:0]  : rd_val[7:0]};

  always_ff @(posedge wb_clk_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
      cfg_o    <= '0;
    end else begin
      wb_ack_o <= access;
      if (access && wb_we_i) begin
        case (reg_sel)
          H_TOTAL:      cfg_o.h_total      <= wr_val[9:0];
          H_DISP:       cfg_o.h_disp       <= wr_val[9:0];
          H_SYNC_START: cfg_o.h_sync_start <= wr_val[9:0];
          H_SYNC_END:   cfg_o.h_sync_end   <= wr_val[9:0];
          V_TOTAL:      cfg_o.v_total      <= wr_val[9:0];
          V_DISP:       cfg_o.v_disp       <= wr_val[9:0];
          V_SYNC_START: cfg_o.v_sync_start <= wr_val[9:0];
          V_SYNC_END:   cfg_o.v_sync_end   <= wr_val[9:0];
          START_ADDR:   cfg_o.start_addr   <= wr_val;
          MAP_MASK:     cfg_o.map_mask     <= wr_val[1:0];
          default:      ;
        endcase
      end
    end
  end

  // Read data goes out together with the ack
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      wb_dat_o <= rd_val;
    end
  end

endmodule

// ==== rtl/vga_pkg.sv ====
// VGA shared definitions for the register map, configuration record and memory requests
package vga_pkg;

  // Default SRAM word address width
  localparam int ADDR_W_DEF = 16;

  // Configuration registers, selected by wb_adr_i[3:0]
  typedef enum logic [3:0] {
    H_TOTAL      = 4'd0,
    H_DISP       = 4'd1,
    H_SYNC_START = 4'd2,
    H_SYNC_END   = 4'd3,
    V_TOTAL      = 4'd4,
    V_DISP       = 4'd5,
    V_SYNC_START = 4'd6,
    V_SYNC_END   = 4'd7,
    START_ADDR   = 4'd8,
    MAP_MASK     = 4'd9
  } cfg_reg_e;

  typedef struct packed {
    logic [9:0]  h_total;
    logic [9:0]  h_disp;
    logic [9:0]  h_sync_start;
    logic [9:0]  h_sync_end;
    logic [9:0]  v_total;
    logic [9:0]  v_disp;
    logic [9:0]  v_sync_start;
    logic [9:0]  v_sync_end;
    logic [15:0] start_addr;
    // Bit 0 low byte, bit 1 high byte
    logic [1:0]  map_mask;
  } vga_cfg_t;

  // One word request towards the SRAM arbiter
  typedef struct packed {
    logic [15:0] addr;
    logic        we;
    logic [1:0]  sel;
    logic [15:0] wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_DATA,
    ACK
  } cpu_state_e;

endpackage
